// ==== design/wb_pkg.sv ====
// Shared definitions for the write-back subsystem
// Width localparams, register index type, MPU and trap cause enums
// Packed structs for the EX/WB pipe, LSU response, coprocessor result
// and controller commands

package wb_pkg;

  ////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////

  // Data path width
  localparam int XLEN     = 32;
  // Number of architectural registers
  localparam int RF_DEPTH = 32;
  // Retire counter width, the counter wraps
  localparam int CNT_W    = 16;

  // Register index, five bits for 32 registers
  typedef logic [$clog2(RF_DEPTH)-1:0] rf_addr_t;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Access check result returned with every LSU response
  typedef enum logic [1:0] {
    MPU_OK       = 2'd0,
    MPU_RE_FAULT = 2'd1,
    MPU_WR_FAULT = 2'd2
  } mpu_status_e;

  // Reason reported with the trap pulse
  typedef enum logic [2:0] {
    CAUSE_NONE        = 3'd0,
    CAUSE_LOAD_FAULT  = 3'd1,
    CAUSE_STORE_FAULT = 3'd2,
    CAUSE_WATCHPOINT  = 3'd3,
    CAUSE_XIF_EXC     = 3'd4,
    CAUSE_ABORT       = 3'd5
  } cause_e;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////

  // Instruction state carried from EX into write-back
  typedef struct packed {
    logic            instr_valid;
    logic            rf_we;
    rf_addr_t        rf_waddr;
    logic [XLEN-1:0] rf_wdata;     // ALU result
    logic            lsu_en;
    logic            lsu_store;    // Picks the store fault cause over the load one
    logic            xif_en;
    logic            abort_op;     // Exception already flagged upstream
  } ex_wb_pipe_t;

  // One-cycle response strobed by the LSU
  typedef struct packed {
    logic [XLEN-1:0] rdata;
    mpu_status_e     mpu_status;
    logic            wpt_match;
  } lsu_resp_t;

  // Result handed back by the coprocessor
  typedef struct packed {
    logic [XLEN-1:0] data;
    logic            exc;
  } xif_result_t;

  // Commands from the controller to the stage
  typedef struct packed {
    logic halt_wb;
    logic kill_wb;
  } ctrl_wb_t;

endpackage

// ==== design/pipe_reg.sv ====
// Generic stage register with a valid bit and a typed payload
// Load, hold and clear control for the valid bit

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     load_i,
  input  logic     clear_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Valid bit is control state and sees the reset
  // A load wins over a clear in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (load_i) begin
      valid_q <= valid_i;
    end else if (clear_i) begin
      valid_q <= 1'b0;
    end
  end

  // Payload only moves on a load so a stalled item stays in place
  always_ff @(posedge clk) begin
    if (load_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

// ==== design/wb_stage.sv ====
// Write-back stage
// Result select between ALU, load data and coprocessor data
// Sticky copy of the LSU response until the stage completes
// Stall, ready and valid generation plus abort and cause detection

module wb_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  wb_pkg::ex_wb_pipe_t      ex_wb_pipe_i,
  input  wb_pkg::ctrl_wb_t         ctrl_wb_i,
  input  logic                     lsu_valid_i,
  input  wb_pkg::lsu_resp_t        lsu_resp_i,
  input  logic                     xif_valid_i,
  input  wb_pkg::xif_result_t      xif_result_i,
  output logic                     xif_ready_o,
  output logic                     lsu_req_o,
  output logic                     rf_we_o,
  output wb_pkg::rf_addr_t         rf_waddr_o,
  output logic [wb_pkg::XLEN-1:0]  rf_wdata_o,
  output logic                     wb_ready_o,
  output logic                     wb_valid_o,
  output logic                     data_stall_o,
  output logic                     abort_op_o,
  output wb_pkg::cause_e           cause_o,
  output wb_pkg::mpu_status_e      mpu_status_o,
  output logic                     wpt_match_o
);

  import wb_pkg::*;

  logic      instr_valid;
  logic      wb_valid;
  logic      lsu_valid_q;
  lsu_resp_t lsu_resp_q;
  logic      lsu_valid;
  lsu_resp_t lsu_resp;
  logic      lsu_waiting;
  logic      lsu_fault;
  logic      wpt_hit;
  logic      xif_waiting;
  logic      xif_exception;

  // Instruction may act only when neither halted nor killed
  assign instr_valid = ex_wb_pipe_i.instr_valid && !ctrl_wb_i.kill_wb && !ctrl_wb_i.halt_wb;

  ////////////////////////////////////////
  // Sticky LSU response
  ////////////////////////////////////////

  // Request stays up while the load or store sits here, halted or not
  assign lsu_req_o = ex_wb_pipe_i.instr_valid && ex_wb_pipe_i.lsu_en;

  // The valid flag is control state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_valid_q <= 1'b0;
    end else if (wb_valid || ctrl_wb_i.kill_wb) begin
      // Stage is done with this access so drop the copy
      lsu_valid_q <= 1'b0;
    end else if (lsu_valid_i && lsu_req_o) begin
      lsu_valid_q <= 1'b1;
    end
  end

  // Response payload is only looked at while lsu_valid_q is set
  always_ff @(posedge clk) begin
    if (lsu_valid_i && lsu_req_o && !lsu_valid_q) begin
      lsu_resp_q <= lsu_resp_i;
    end
  end

  // Held copy wins over whatever the LSU drives now
  assign lsu_valid = lsu_valid_q || lsu_valid_i;
  assign lsu_resp  = lsu_valid_q ? lsu_resp_q : lsu_resp_i;

  assign lsu_waiting = lsu_req_o && !lsu_valid;
  assign lsu_fault   = lsu_req_o && lsu_valid && (lsu_resp.mpu_status != MPU_OK);
  assign wpt_hit     = lsu_req_o && lsu_valid && lsu_resp.wpt_match;

  // Status outputs read as clean when no response is present
  assign mpu_status_o = lsu_valid ? lsu_resp.mpu_status : MPU_OK;
  assign wpt_match_o  = lsu_valid && lsu_resp.wpt_match;

  ////////////////////////////////////////
  // Coprocessor result
  ////////////////////////////////////////

  assign xif_waiting   = ex_wb_pipe_i.instr_valid && ex_wb_pipe_i.xif_en && !xif_valid_i;
  assign xif_exception = ex_wb_pipe_i.instr_valid && ex_wb_pipe_i.xif_en && xif_valid_i &&
                         xif_result_i.exc;

  // Result is consumed when the instruction leaves, by retiring or by a kill
  assign xif_ready_o = ex_wb_pipe_i.instr_valid && ex_wb_pipe_i.xif_en && xif_valid_i &&
                       (ctrl_wb_i.kill_wb || !ctrl_wb_i.halt_wb);

  ////////////////////////////////////////
  // Stage handshake
  ////////////////////////////////////////

  // A kill always frees the stage, otherwise halt and pending results hold it
  assign wb_ready_o = ctrl_wb_i.kill_wb ||
                      (!ctrl_wb_i.halt_wb && !xif_waiting && !lsu_waiting);

  // Loads and stores finish on a response, everything else once any coprocessor data is in
  assign wb_valid = instr_valid &&
                    (ex_wb_pipe_i.lsu_en ? lsu_valid : !xif_waiting);
  assign wb_valid_o = wb_valid;

  assign data_stall_o = instr_valid && ex_wb_pipe_i.lsu_en && !lsu_valid;

  // Any exception source ends the instruction without a register write
  assign abort_op_o = ex_wb_pipe_i.abort_op || lsu_fault || wpt_hit || xif_exception;

  always_comb begin
    cause_o = CAUSE_NONE;
    if (ex_wb_pipe_i.abort_op) begin
      cause_o = CAUSE_ABORT;
    end else if (lsu_fault) begin
      cause_o = ex_wb_pipe_i.lsu_store ? CAUSE_STORE_FAULT : CAUSE_LOAD_FAULT;
    end else if (wpt_hit) begin
      cause_o = CAUSE_WATCHPOINT;
    end else if (xif_exception) begin
      cause_o = CAUSE_XIF_EXC;
    end
  end

  ////////////////////////////////////////
  // Register file write
  ////////////////////////////////////////

  // wb_valid already covers halt, kill and the coprocessor wait
  assign rf_we_o    = ex_wb_pipe_i.rf_we && wb_valid && !abort_op_o;
  assign rf_waddr_o = ex_wb_pipe_i.rf_waddr;
  assign rf_wdata_o = ex_wb_pipe_i.lsu_en ? lsu_resp.rdata    :
                      ex_wb_pipe_i.xif_en ? xif_result_i.data :
                      ex_wb_pipe_i.rf_wdata;

endmodule

// ==== design/regfile.sv ====
// Register file with 32 entries of XLEN bits
// One synchronous write port and one asynchronous read port
// Register x0 always reads as zero

module regfile (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     we_i,
  input  wb_pkg::rf_addr_t         waddr_i,
  input  logic [wb_pkg::XLEN-1:0]  wdata_i,
  input  wb_pkg::rf_addr_t         raddr_i,
  output logic [wb_pkg::XLEN-1:0]  rdata_o
);

  import wb_pkg::*;

  logic [XLEN-1:0] mem_q [RF_DEPTH];

  // All registers start out at zero
  // Writes aimed at x0 are dropped so the entry stays zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < RF_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational read with x0 forced to zero
  always_comb begin
    if (raddr_i == '0) begin
      rdata_o = '0;
    end else begin
      rdata_o = mem_q[raddr_i];
    end
  end

endmodule

// ==== design/wb_ctrl.sv ====
// Write-back controller
// Halt pass-through, RUN and FLUSH machine for the post-abort kill
// Trap pulse with registered cause and a wrapping retire counter

module wb_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      halt_req_i,
  input  logic                      wb_valid_i,
  input  logic                      abort_op_i,
  input  wb_pkg::cause_e            cause_i,
  output wb_pkg::ctrl_wb_t          ctrl_wb_o,
  output logic                      trap_o,
  output wb_pkg::cause_e            trap_cause_o,
  output logic [wb_pkg::CNT_W-1:0]  retire_cnt_o
);

  import wb_pkg::*;

  typedef enum logic {
    RUN   = 1'b0,
    FLUSH = 1'b1
  } state_e;

  state_e           state_q;
  state_e           state_d;
  cause_e           cause_q;
  logic [CNT_W-1:0] cnt_q;
  logic             abort_retire;

  // An instruction that retires with an abort
  assign abort_retire = wb_valid_i && abort_op_i;

  ////////////////////////////////////////
  // Flush machine
  ////////////////////////////////////////

  // FLUSH lasts a single cycle and always returns to RUN
  always_comb begin
    state_d = state_q;
    case (state_q)
      RUN: begin
        if (abort_retire) begin
          state_d = FLUSH;
        end
      end
      FLUSH: begin
        state_d = RUN;
      end
      default: begin
        state_d = RUN;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RUN;
      cause_q <= CAUSE_NONE;
    end else begin
      state_q <= state_d;
      // Cause is sampled together with the aborting retire
      if (abort_retire) begin
        cause_q <= cause_i;
      end
    end
  end

  // Halt follows the request level with no delay
  assign ctrl_wb_o.halt_wb = halt_req_i;
  // Kill removes the instruction right behind the aborting one
  assign ctrl_wb_o.kill_wb = (state_q == FLUSH);
  assign trap_o            = (state_q == FLUSH);
  assign trap_cause_o      = cause_q;

  ////////////////////////////////////////
  // Retire counter
  ////////////////////////////////////////

  // Aborting instructions do not count, overflow wraps to zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (wb_valid_i && !abort_op_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign retire_cnt_o = cnt_q;

endmodule

// ==== design/wb_subsys.sv ====
// Write-back subsystem top level
// EX/WB register, coprocessor result register, write-back stage,
// register file and controller with the EX ready term

module wb_subsys (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      ex_valid_i,
  input  wb_pkg::ex_wb_pipe_t       ex_pipe_i,
  output logic                      ex_ready_o,
  output logic                      lsu_req_o,
  input  logic                      lsu_valid_i,
  input  wb_pkg::lsu_resp_t         lsu_resp_i,
  input  logic                      xif_valid_i,
  input  wb_pkg::xif_result_t       xif_result_i,
  input  logic                      halt_req_i,
  input  wb_pkg::rf_addr_t          rs_addr_i,
  output logic [wb_pkg::XLEN-1:0]   rs_data_o,
  output logic                      wb_valid_o,
  output logic                      data_stall_o,
  output logic                      trap_o,
  output wb_pkg::cause_e            trap_cause_o,
  output logic [wb_pkg::CNT_W-1:0]  retire_cnt_o
);

  import wb_pkg::*;

  logic            ex_wb_valid;
  ex_wb_pipe_t     ex_wb_q;
  ex_wb_pipe_t     ex_wb_pipe;
  logic            xif_res_valid;
  xif_result_t     xif_res_q;
  logic            xif_ready;
  logic            wb_ready;
  logic            wb_valid;
  logic            abort_op;
  cause_e          cause;
  ctrl_wb_t        ctrl_wb;
  logic            rf_we;
  rf_addr_t        rf_waddr;
  logic [XLEN-1:0] rf_wdata;

  ////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////

  // Accept when the register is empty or the stage lets its instruction go
  assign ex_ready_o = !ex_wb_valid || wb_ready;

  pipe_reg #(.payload_t(ex_wb_pipe_t)) u_ex_wb_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .load_i  (ex_ready_o),
    .clear_i (ctrl_wb.kill_wb && wb_ready),
    .valid_i (ex_valid_i),
    .data_i  (ex_pipe_i),
    .valid_o (ex_wb_valid),
    .data_o  (ex_wb_q)
  );

  // The register's valid bit is what marks the stage as occupied
  always_comb begin
    ex_wb_pipe             = ex_wb_q;
    ex_wb_pipe.instr_valid = ex_wb_valid;
  end

  // Coprocessor result waits here until the stage consumes it
  pipe_reg #(.payload_t(xif_result_t)) u_xif_res_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .load_i  (xif_valid_i),
    .clear_i (xif_ready),
    .valid_i (xif_valid_i),
    .data_i  (xif_result_i),
    .valid_o (xif_res_valid),
    .data_o  (xif_res_q)
  );

  ////////////////////////////////////////
  // Stage, register file, controller
  ////////////////////////////////////////

  wb_stage u_wb_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_wb_pipe_i (ex_wb_pipe),
    .ctrl_wb_i    (ctrl_wb),
    .lsu_valid_i  (lsu_valid_i),
    .lsu_resp_i   (lsu_resp_i),
    .xif_valid_i  (xif_res_valid),
    .xif_result_i (xif_res_q),
    .xif_ready_o  (xif_ready),
    .lsu_req_o    (lsu_req_o),
    .rf_we_o      (rf_we),
    .rf_waddr_o   (rf_waddr),
    .rf_wdata_o   (rf_wdata),
    .wb_ready_o   (wb_ready),
    .wb_valid_o   (wb_valid),
    .data_stall_o (data_stall_o),
    .abort_op_o   (abort_op),
    .cause_o      (cause),
    .mpu_status_o (),
    .wpt_match_o  ()
  );

  regfile u_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata),
    .raddr_i (rs_addr_i),
    .rdata_o (rs_data_o)
  );

  wb_ctrl u_wb_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .halt_req_i   (halt_req_i),
    .wb_valid_i   (wb_valid),
    .abort_op_i   (abort_op),
    .cause_i      (cause),
    .ctrl_wb_o    (ctrl_wb),
    .trap_o       (trap_o),
    .trap_cause_o (trap_cause_o),
    .retire_cnt_o (retire_cnt_o)
  );

  assign wb_valid_o = wb_valid;

endmodule

// ==== testbench/tb_wb_subsys.sv ====
// Testbench for the write-back subsystem
// Clock, reset, DUT, value check and wait helpers with timeouts
// Shadow register model and directed tests for ALU writes, loads, halt,
// faults, coprocessor results and back-pressure

module tb_wb_subsys;

  import wb_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY  = 5;
  localparam int RST_CYCLES = 10;
  localparam int TIMEOUT    = 64;

  logic              clk;
  logic              rst_n;
  logic              ex_valid_i;
  ex_wb_pipe_t       ex_pipe_i;
  logic              ex_ready_o;
  logic              lsu_req_o;
  logic              lsu_valid_i;
  lsu_resp_t         lsu_resp_i;
  logic              xif_valid_i;
  xif_result_t       xif_result_i;
  logic              halt_req_i;
  rf_addr_t          rs_addr_i;
  logic [XLEN-1:0]   rs_data_o;
  logic              wb_valid_o;
  logic              data_stall_o;
  logic              trap_o;
  cause_e            trap_cause_o;
  logic [CNT_W-1:0]  retire_cnt_o;

  // Predicted register file contents and retire count
  logic [XLEN-1:0]   shadow [RF_DEPTH];
  int unsigned       exp_cnt;
  integer            seed;

  wb_subsys dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic abort_sim();
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("ERR @%0t: %s got 0x%0h expected 0x%0h", $time, what, actual, expected);
      abort_sim();
    end
  endtask

  // Inputs change a short delay after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic drive_idle();
    ex_valid_i   = 1'b0;
    ex_pipe_i    = '0;
    lsu_valid_i  = 1'b0;
    lsu_resp_i   = '0;
    xif_valid_i  = 1'b0;
    xif_result_i = '0;
    halt_req_i   = 1'b0;
    rs_addr_i    = '0;
  endtask

  function automatic ex_wb_pipe_t make_op(input rf_addr_t rd, input logic [XLEN-1:0] data,
                                          input logic lsu, input logic xif);
    ex_wb_pipe_t op;
    op             = '0;
    op.instr_valid = 1'b1;
    op.rf_we       = 1'b1;
    op.rf_waddr    = rd;
    op.rf_wdata    = data;
    op.lsu_en      = lsu;
    op.xif_en      = xif;
    return op;
  endfunction

  // Destination in x1 to x31 so that a write can be seen
  function automatic rf_addr_t rand_reg();
    logic [31:0] r;
    r = $random(seed);
    return rf_addr_t'(r % 31 + 1);
  endfunction

  // Hold the instruction on the EX side until the DUT takes it
  task automatic issue_instr(input ex_wb_pipe_t op);
    int n;
    n          = 0;
    ex_valid_i = 1'b1;
    ex_pipe_i  = op;
    @(negedge clk);
    while (!ex_ready_o) begin
      n++;
      if (n > TIMEOUT) begin
        $display("Timeout: the EX/WB register never accepted the instruction");
        abort_sim();
      end
      @(negedge clk);
    end
    next_cycle();
  endtask

  task automatic wait_wb_valid();
    int n;
    n = 0;
    @(negedge clk);
    while (!wb_valid_o) begin
      n++;
      if (n > TIMEOUT) begin
        $display("Timeout: no instruction retired from write-back");
        abort_sim();
      end
      @(negedge clk);
    end
  endtask

  task automatic wait_lsu_req();
    int n;
    n = 0;
    @(negedge clk);
    while (!lsu_req_o) begin
      n++;
      if (n > TIMEOUT) begin
        $display("Timeout: the LSU request never came up");
        abort_sim();
      end
      @(negedge clk);
    end
  endtask

  // One response strobe, held until the load leaves write-back
  task automatic respond_load(input logic [XLEN-1:0] data, input mpu_status_e status,
                              input logic wpt);
    lsu_valid_i           = 1'b1;
    lsu_resp_i.rdata      = data;
    lsu_resp_i.mpu_status = status;
    lsu_resp_i.wpt_match  = wpt;
    wait_wb_valid();
    next_cycle();
    lsu_valid_i = 1'b0;
  endtask

  task automatic give_xif_result(input logic [XLEN-1:0] data, input logic exc);
    xif_valid_i       = 1'b1;
    xif_result_i.data = data;
    xif_result_i.exc  = exc;
    next_cycle();
    xif_valid_i = 1'b0;
  endtask

  task automatic expect_reg(input rf_addr_t addr);
    rs_addr_i = addr;
    @(negedge clk);
    check_eq(rs_data_o, shadow[addr], $sformatf("register x%0d", addr));
    next_cycle();
  endtask

  task automatic check_all_regs();
    for (int i = 0; i < RF_DEPTH; i++) begin
      expect_reg(rf_addr_t'(i));
    end
  endtask

  // Trap comes the cycle after the aborting retire and lasts one cycle
  task automatic expect_trap(input cause_e cause);
    @(negedge clk);
    check_eq(32'(trap_o), 1, "trap_o pulse");
    check_eq(32'(trap_cause_o), 32'(cause), "trap_cause_o");
    check_eq(32'(wb_valid_o), 0, "wb_valid_o in the kill cycle");
    next_cycle();
    @(negedge clk);
    check_eq(32'(trap_o), 0, "trap_o one cycle later");
    next_cycle();
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic alu_burst();
    rf_addr_t        rd;
    logic [XLEN-1:0] data;
    for (int i = 0; i < 24; i++) begin
      rd   = rf_addr_t'($random(seed));
      data = $random(seed);
      issue_instr(make_op(rd, data, 1'b0, 1'b0));
      // x0 takes no write
      if (rd != '0) begin
        shadow[rd] = data;
      end
      exp_cnt++;
    end
    ex_valid_i = 1'b0;
    wait_wb_valid();
    next_cycle();
    check_all_regs();
    check_eq(32'(retire_cnt_o), exp_cnt, "retire_cnt_o after ALU burst");
  endtask

  task automatic late_load();
    rf_addr_t        rd;
    logic [XLEN-1:0] rdata;
    int              delay;
    rd    = rand_reg();
    rdata = $random(seed);
    delay = 1 + ($random(seed) & 3);
    // The ALU field carries a different value so a wrong select shows up
    issue_instr(make_op(rd, ~rdata, 1'b1, 1'b0));
    ex_valid_i = 1'b0;
    wait_lsu_req();
    repeat (delay) begin
      check_eq(32'(data_stall_o), 1, "data_stall_o while the load waits");
      check_eq(32'(wb_valid_o), 0, "wb_valid_o while the load waits");
      next_cycle();
      @(negedge clk);
    end
    next_cycle();
    respond_load(rdata, MPU_OK, 1'b0);
    shadow[rd] = rdata;
    exp_cnt++;
    expect_reg(rd);
  endtask

  task automatic halted_load();
    rf_addr_t        rd;
    logic [XLEN-1:0] rdata;
    rd    = rand_reg();
    rdata = $random(seed);
    issue_instr(make_op(rd, ~rdata, 1'b1, 1'b0));
    ex_valid_i = 1'b0;
    halt_req_i = 1'b1;
    wait_lsu_req();
    next_cycle();
    lsu_valid_i           = 1'b1;
    lsu_resp_i.rdata      = rdata;
    lsu_resp_i.mpu_status = MPU_OK;
    lsu_resp_i.wpt_match  = 1'b0;
    @(negedge clk);
    check_eq(32'(wb_valid_o), 0, "wb_valid_o with the response under halt");
    next_cycle();
    // Live response now differs, only the captured copy may be written
    lsu_valid_i      = 1'b0;
    lsu_resp_i.rdata = ~rdata;
    repeat (3) begin
      @(negedge clk);
      check_eq(32'(wb_valid_o), 0, "wb_valid_o while halted");
      check_eq(32'(ex_ready_o), 0, "ex_ready_o while halted");
      next_cycle();
    end
    halt_req_i = 1'b0;
    wait_wb_valid();
    next_cycle();
    shadow[rd] = rdata;
    exp_cnt++;
    expect_reg(rd);
  endtask

  task automatic fault_and_watchpoint();
    rf_addr_t ld_rd;
    rf_addr_t alu_rd;
    rf_addr_t wp_rd;
    ld_rd  = rand_reg();
    alu_rd = rand_reg();
    wp_rd  = rand_reg();
    issue_instr(make_op(ld_rd, $random(seed), 1'b1, 1'b0));
    // Next instruction waits on the EX side and enters as the load retires
    ex_valid_i = 1'b1;
    ex_pipe_i  = make_op(alu_rd, $random(seed), 1'b0, 1'b0);
    wait_lsu_req();
    check_eq(32'(ex_ready_o), 0, "ex_ready_o behind a waiting load");
    next_cycle();
    respond_load($random(seed), MPU_RE_FAULT, 1'b0);
    ex_valid_i = 1'b0;
    expect_trap(CAUSE_LOAD_FAULT);
    expect_reg(ld_rd);
    expect_reg(alu_rd);
    check_eq(32'(retire_cnt_o), exp_cnt, "retire_cnt_o after the fault");
    // Watchpoint hit on a clean access
    issue_instr(make_op(wp_rd, $random(seed), 1'b1, 1'b0));
    ex_valid_i = 1'b0;
    wait_lsu_req();
    next_cycle();
    respond_load($random(seed), MPU_OK, 1'b1);
    expect_trap(CAUSE_WATCHPOINT);
    expect_reg(wp_rd);
    check_eq(32'(retire_cnt_o), exp_cnt, "retire_cnt_o after the watchpoint");
  endtask

  task automatic coproc_ops();
    rf_addr_t        rd;
    rf_addr_t        exc_rd;
    logic [XLEN-1:0] data;
    rd     = rand_reg();
    exc_rd = rand_reg();
    data   = $random(seed);
    issue_instr(make_op(rd, ~data, 1'b0, 1'b1));
    ex_valid_i = 1'b0;
    @(negedge clk);
    check_eq(32'(wb_valid_o), 0, "wb_valid_o before the coprocessor result");
    check_eq(32'(ex_ready_o), 0, "ex_ready_o before the coprocessor result");
    next_cycle();
    give_xif_result(data, 1'b0);
    wait_wb_valid();
    next_cycle();
    shadow[rd] = data;
    exp_cnt++;
    expect_reg(rd);
    // Same flow with the exception flag set
    issue_instr(make_op(exc_rd, $random(seed), 1'b0, 1'b1));
    ex_valid_i = 1'b0;
    give_xif_result($random(seed), 1'b1);
    wait_wb_valid();
    next_cycle();
    expect_trap(CAUSE_XIF_EXC);
    expect_reg(exc_rd);
    check_eq(32'(retire_cnt_o), exp_cnt, "retire_cnt_o after coprocessor ops");
  endtask

  task automatic backpressure_order();
    rf_addr_t        rd;
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] alu_data;
    int              delay;
    rd       = rand_reg();
    rdata    = $random(seed);
    alu_data = $random(seed);
    delay    = 1 + ($random(seed) & 3);
    issue_instr(make_op(rd, ~rdata, 1'b1, 1'b0));
    // Both target the same register so the final value shows the order
    ex_valid_i = 1'b1;
    ex_pipe_i  = make_op(rd, alu_data, 1'b0, 1'b0);
    wait_lsu_req();
    repeat (delay) begin
      check_eq(32'(ex_ready_o), 0, "ex_ready_o under back-pressure");
      check_eq(32'(data_stall_o), 1, "data_stall_o under back-pressure");
      next_cycle();
      @(negedge clk);
    end
    next_cycle();
    respond_load(rdata, MPU_OK, 1'b0);
    ex_valid_i = 1'b0;
    shadow[rd] = rdata;
    exp_cnt++;
    expect_reg(rd);
    shadow[rd] = alu_data;
    exp_cnt++;
    expect_reg(rd);
    check_eq(32'(retire_cnt_o), exp_cnt, "retire_cnt_o after back-pressure");
  endtask

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////

  initial begin
    seed    = 32'h182c_8a47;
    exp_cnt = 0;
    rst_n   = 1'b0;
    drive_idle();
    for (int i = 0; i < RF_DEPTH; i++) begin
      shadow[i] = '0;
    end
    repeat (RST_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    @(negedge clk);
    check_eq(32'(wb_valid_o), 0, "wb_valid_o after reset");
    check_eq(32'(lsu_req_o), 0, "lsu_req_o after reset");
    check_eq(32'(data_stall_o), 0, "data_stall_o after reset");
    check_eq(32'(trap_o), 0, "trap_o after reset");
    check_eq(32'(retire_cnt_o), 0, "retire_cnt_o after reset");
    next_cycle();
    alu_burst();
    late_load();
    halted_load();
    fault_and_watchpoint();
    coproc_ops();
    backpressure_order();
    check_all_regs();
    check_eq(32'(retire_cnt_o), exp_cnt, "final retire count");
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== vlog.f ====
design/wb_pkg.sv
design/pipe_reg.sv
design/wb_stage.sv
design/regfile.sv
design/wb_ctrl.sv
design/wb_subsys.sv
testbench/tb_wb_subsys.sv

// ==== Makefile ====
# Verilator build and run for the write-back subsystem

VERILATOR  ?= verilator
TOP        ?= tb_wb_subsys
RTL_TOP    ?= wb_subsys
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail is taken from the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
